//--- common/integral_pkg.sv
package integral_pkg;

  // ----------------------------------------------------------------------
  // Frame geometry
  // ----------------------------------------------------------------------
  localparam int COLS  = 7;
  localparam int ROWS  = 5;
  localparam int PIX_W = 8;
  // Holds ROWS*COLS*255 without overflow
  localparam int SUM_W = 14;
  localparam int COL_W = $clog2(COLS);
  localparam int ROW_W = $clog2(ROWS);

  // ----------------------------------------------------------------------
  // Sequencer FSM
  // ----------------------------------------------------------------------
  typedef enum logic [1:0] {
    SEQ_IDLE      = 2'd0,
    SEQ_ROW_START = 2'd1,
    SEQ_ROW_RUN   = 2'd2,
    SEQ_FINISH    = 2'd3
  } seq_state_e;

  // ----------------------------------------------------------------------
  // Stage beats
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [PIX_W-1:0] pix;
    logic             first_col;
    logic             first_row;
    logic             last_pix;
  } pix_beat_t;

  typedef struct packed {
    logic [SUM_W-1:0] row_sum;
    logic             first_col;
    logic             first_row;
    logic             last_pix;
  } prefix_beat_t;

  typedef struct packed {
    logic [SUM_W-1:0] sum;
    logic             last_pix;
  } integral_beat_t;

endpackage

//--- row_sum/frame_sequencer.sv
`timescale 1ns/1ns

module frame_sequencer
  import integral_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             i_start,
  input  logic             i_pix_valid,
  input  logic [PIX_W-1:0] i_pix,
  input  logic             i_ready,
  output logic             o_pix_ready,
  output logic             o_valid,
  output pix_beat_t        o_beat,
  output logic             o_busy
);

  seq_state_e       state;
  seq_state_e       next_state;
  logic [COL_W-1:0] col_cnt;
  logic [ROW_W-1:0] row_cnt;
  logic             valid_q;
  pix_beat_t        beat_q;
  logic             can_load;
  logic             accept;
  logic             last_col;
  logic             last_row;

  assign can_load = !valid_q || i_ready;
  assign accept   = i_pix_valid && o_pix_ready;
  assign last_col = (col_cnt == COL_W'(COLS - 1));
  assign last_row = (row_cnt == ROW_W'(ROWS - 1));

  // ----------------------------------------------------------------------
  // FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= SEQ_IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state  = state;
    o_pix_ready = 1'b0;
    o_busy      = (state != SEQ_IDLE);
    case (state)
      SEQ_IDLE: begin
        if (i_start) begin
          next_state = SEQ_ROW_START;
        end
      end
      SEQ_ROW_START, SEQ_ROW_RUN: begin
        o_pix_ready = can_load;
        if (i_pix_valid && can_load) begin
          if (last_col) begin
            next_state = last_row ? SEQ_FINISH : SEQ_ROW_START;
          end else begin
            next_state = SEQ_ROW_RUN;
          end
        end
      end
      SEQ_FINISH: begin
        // Drain the last beat before going idle
        if (!valid_q) begin
          next_state = SEQ_IDLE;
        end
      end
      default: next_state = SEQ_IDLE;
    endcase
  end

  // Position counters
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_cnt <= '0;
      row_cnt <= '0;
    end else if (accept) begin
      if (last_col) begin
        col_cnt <= '0;
        row_cnt <= last_row ? '0 : row_cnt + 1'b1;
      end else begin
        col_cnt <= col_cnt + 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Output register
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (i_ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      beat_q.pix       <= i_pix;
      beat_q.first_col <= (state == SEQ_ROW_START);
      beat_q.first_row <= (row_cnt == '0);
      beat_q.last_pix  <= last_col && last_row;
    end
  end

  assign o_valid = valid_q;
  assign o_beat  = beat_q;

endmodule

//--- row_sum/row_prefix.sv
`timescale 1ns/1ns

module row_prefix
  import integral_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         i_valid,
  input  pix_beat_t    i_beat,
  input  logic         i_ready,
  output logic         o_ready,
  output logic         o_valid,
  output prefix_beat_t o_beat
);

  logic             valid_q;
  prefix_beat_t     beat_q;
  logic             xfer_in;
  logic [SUM_W-1:0] pix_ext;

  assign o_ready = !valid_q || i_ready;
  assign xfer_in = i_valid && o_ready;
  assign pix_ext = {{(SUM_W - PIX_W){1'b0}}, i_beat.pix};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (xfer_in) begin
      valid_q <= 1'b1;
    end else if (i_ready) begin
      valid_q <= 1'b0;
    end
  end

  // Running sum is kept in the output register
  always_ff @(posedge clk) begin
    if (xfer_in) begin
      if (i_beat.first_col) begin
        beat_q.row_sum <= pix_ext;
      end else begin
        beat_q.row_sum <= beat_q.row_sum + pix_ext;
      end
      beat_q.first_col <= i_beat.first_col;
      beat_q.first_row <= i_beat.first_row;
      beat_q.last_pix  <= i_beat.last_pix;
    end
  end

  assign o_valid = valid_q;
  assign o_beat  = beat_q;

endmodule

//--- logic/column_accum.sv
`timescale 1ns/1ns

module column_accum
  import integral_pkg::*;
(
  input  logic           clk,
  input  logic           rst_n,
  input  logic           i_valid,
  input  prefix_beat_t   i_beat,
  input  logic           i_ready,
  output logic           o_ready,
  output logic           o_valid,
  output integral_beat_t o_beat,
  output logic           o_frame_done
);

  logic [SUM_W-1:0] line_buf [COLS];
  logic [COL_W-1:0] col_idx;
  logic [COL_W-1:0] cur_col;
  logic [SUM_W-1:0] new_sum;
  logic             valid_q;
  integral_beat_t   beat_q;
  logic             xfer_in;

  assign o_ready = !valid_q || i_ready;
  assign xfer_in = i_valid && o_ready;
  assign cur_col = i_beat.first_col ? '0 : col_idx;

  // First row ignores whatever the buffer holds from the previous frame
  assign new_sum = i_beat.first_row ? i_beat.row_sum
                                    : i_beat.row_sum + line_buf[cur_col];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_idx <= '0;
    end else if (xfer_in) begin
      col_idx <= cur_col + 1'b1;
    end
  end

  // Buffer always holds the row above
  always_ff @(posedge clk) begin
    if (xfer_in) begin
      line_buf[cur_col] <= new_sum;
    end
  end

  // ----------------------------------------------------------------------
  // Output register
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (xfer_in) begin
      valid_q <= 1'b1;
    end else if (i_ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (xfer_in) begin
      beat_q.sum      <= new_sum;
      beat_q.last_pix <= i_beat.last_pix;
    end
  end

  assign o_valid      = valid_q;
  assign o_beat       = beat_q;
  assign o_frame_done = valid_q && i_ready && beat_q.last_pix;

endmodule

//--- logic/integral_top.sv
`timescale 1ns/1ns

module integral_top
  import integral_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             i_start,
  input  logic             i_pix_valid,
  input  logic [PIX_W-1:0] i_pix,
  input  logic             i_out_ready,
  output logic             o_pix_ready,
  output logic             o_out_valid,
  output integral_beat_t   o_out,
  output logic             o_busy,
  output logic             o_frame_done
);

  logic         s1_valid;
  logic         s1_ready;
  pix_beat_t    s1_beat;
  logic         s2_valid;
  logic         s2_ready;
  prefix_beat_t s2_beat;

  // Stage 1 tags each pixel with its position
  frame_sequencer frame_sequencer_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_start     (i_start),
    .i_pix_valid (i_pix_valid),
    .i_pix       (i_pix),
    .i_ready     (s1_ready),
    .o_pix_ready (o_pix_ready),
    .o_valid     (s1_valid),
    .o_beat      (s1_beat),
    .o_busy      (o_busy)
  );

  row_prefix row_prefix_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_valid (s1_valid),
    .i_beat  (s1_beat),
    .i_ready (s2_ready),
    .o_ready (s1_ready),
    .o_valid (s2_valid),
    .o_beat  (s2_beat)
  );

  column_accum column_accum_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_valid      (s2_valid),
    .i_beat       (s2_beat),
    .i_ready      (i_out_ready),
    .o_ready      (s2_ready),
    .o_valid      (o_out_valid),
    .o_beat       (o_out),
    .o_frame_done (o_frame_done)
  );

endmodule

//--- test/integral_tb.sv
`timescale 1ns/1ns

module integral_tb
  import integral_pkg::*;
();

  localparam int FRAME_PIX = ROWS * COLS;
  localparam int FRAMES    = 3;
  localparam int TIMEOUT   = 1000;

  logic           clk         = 1'b0;
  logic           rst_n       = 1'b0;
  logic           i_start     = 1'b0;
  logic           i_pix_valid = 1'b0;
  logic [PIX_W-1:0] i_pix     = '0;
  logic           i_out_ready = 1'b0;
  logic           o_pix_ready;
  logic           o_out_valid;
  integral_beat_t o_out;
  logic           o_busy;
  logic           o_frame_done;

  // Stimulus state
  logic [15:0] lfsr     = 16'd61343;
  logic        drive_en = 1'b0;
  int          armed    = 0;
  int          sent     = 0;

  // Reference model state
  logic [PIX_W-1:0] img [ROWS][COLS];
  logic [SUM_W-1:0] exp_q [$];
  logic [SUM_W-1:0] exp_head    = '0;
  int               exp_cnt     = 0;
  int               acc_idx     = 0;
  int               acc_total   = 0;
  int               out_idx     = 0;
  int               out_total   = 0;
  int               frames_seen = 0;
  logic             frame_open  = 1'b0;

  int value_errs   = 0;
  int proto_errs   = 0;
  int count_errs   = 0;
  int timeout_errs = 0;

  always #10 clk = ~clk;

  integral_top integral_top_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_start      (i_start),
    .i_pix_valid  (i_pix_valid),
    .i_pix        (i_pix),
    .i_out_ready  (i_out_ready),
    .o_pix_ready  (o_pix_ready),
    .o_out_valid  (o_out_valid),
    .o_out        (o_out),
    .o_busy       (o_busy),
    .o_frame_done (o_frame_done)
  );

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // ----------------------------------------------------------------------
  // Pixel and back-pressure driver
  // ----------------------------------------------------------------------
  always @(posedge clk) begin
    logic [PIX_W-1:0] pix_bits;
    logic [1:0]       gap_bits;
    logic [1:0]       rdy_bits;
    for (int i = 0; i < 2; i++) begin
      rdy_bits[i] = lfsr[0];
      lfsr = lfsr_step(lfsr);
    end
    if (drive_en) begin
      i_out_ready <= (rdy_bits != 2'b00);
    end
    if (i_pix_valid && o_pix_ready) begin
      sent = sent + 1;
    end
    // Hold the pixel until it is taken
    if (!i_pix_valid || o_pix_ready) begin
      for (int i = 0; i < 2; i++) begin
        gap_bits[i] = lfsr[0];
        lfsr = lfsr_step(lfsr);
      end
      for (int i = 0; i < PIX_W; i++) begin
        pix_bits[i] = lfsr[0];
        lfsr = lfsr_step(lfsr);
      end
      if (sent < armed * FRAME_PIX && gap_bits != 2'b00) begin
        i_pix_valid <= 1'b1;
        i_pix       <= pix_bits;
      end else begin
        i_pix_valid <= 1'b0;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Reference model and scoreboard
  // ----------------------------------------------------------------------
  always @(posedge clk) begin
    int r;
    int c;
    int sum;
    if (o_out_valid && i_out_ready) begin
      if (exp_q.size() != 0) begin
        void'(exp_q.pop_front());
      end
      out_idx   <= (out_idx == FRAME_PIX - 1) ? 0 : out_idx + 1;
      out_total <= out_total + 1;
    end
    if (o_frame_done) begin
      frames_seen <= frames_seen + 1;
    end
    if (i_start && !frame_open) begin
      frame_open <= 1'b1;
    end
    if (i_pix_valid && o_pix_ready) begin
      r = acc_idx / COLS;
      c = acc_idx % COLS;
      img[r][c] = i_pix;
      // Sum of all pixels in rows up to r and columns up to c
      sum = 0;
      for (int y = 0; y <= r; y++) begin
        for (int x = 0; x <= c; x++) begin
          sum = sum + int'(img[y][x]);
        end
      end
      exp_q.push_back(SUM_W'(sum));
      if (acc_idx == FRAME_PIX - 1) begin
        acc_idx = 0;
        frame_open <= 1'b0;
      end else begin
        acc_idx = acc_idx + 1;
      end
      acc_total <= acc_total + 1;
    end
    exp_head <= (exp_q.size() != 0) ? exp_q[0] : '0;
    exp_cnt  <= exp_q.size();
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  a_reset_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (acc_total == 0 && !frame_open) |->
      !(o_out_valid || o_frame_done || o_busy || o_pix_ready))
    else begin
      proto_errs++;
      $display("error %0t: DUT not idle before the first start", $time);
    end

  a_no_ready: assert property (@(posedge clk) disable iff (!rst_n)
    !frame_open |-> !o_pix_ready)
    else begin
      proto_errs++;
      $display("error %0t: pixel ready outside a frame", $time);
    end

  a_busy: assert property (@(posedge clk) disable iff (!rst_n)
    frame_open |-> o_busy)
    else begin
      proto_errs++;
      $display("error %0t: busy low while a frame is open", $time);
    end

  a_sum: assert property (@(posedge clk) disable iff (!rst_n)
    (o_out_valid && i_out_ready) |-> (exp_cnt != 0 && o_out.sum == exp_head))
    else begin
      value_errs++;
      $display("error %0t: sum %0d, expected %0d", $time,
               $sampled(o_out.sum), $sampled(exp_head));
    end

  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (o_out_valid && !i_out_ready) |=> (o_out_valid && $stable(o_out)))
    else begin
      proto_errs++;
      $display("error %0t: output changed while stalled", $time);
    end

  a_last: assert property (@(posedge clk) disable iff (!rst_n)
    (o_out_valid && i_out_ready) |-> (o_out.last_pix == (out_idx == FRAME_PIX - 1)))
    else begin
      value_errs++;
      $display("error %0t: last_pix wrong on beat %0d", $time, $sampled(out_idx));
    end

  a_done: assert property (@(posedge clk) disable iff (!rst_n)
    o_frame_done == (o_out_valid && i_out_ready && out_idx == FRAME_PIX - 1))
    else begin
      proto_errs++;
      $display("error %0t: frame done is %0b on beat %0d", $time,
               $sampled(o_frame_done), $sampled(out_idx));
    end

  a_drain: assert property (@(posedge clk) disable iff (!rst_n)
    o_frame_done |-> (exp_cnt == 1))
    else begin
      proto_errs++;
      $display("error %0t: %0d beats pending at frame done", $time, $sampled(exp_cnt));
    end

  task automatic end_run();
    $display("errors: value %0d, protocol %0d, count %0d, timeout %0d",
             value_errs, proto_errs, count_errs, timeout_errs);
    if (value_errs + proto_errs + count_errs + timeout_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  task automatic wait_frames(input int n);
    int cycles;
    cycles = 0;
    while (frames_seen < n && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (frames_seen < n) begin
      $display("timeout: frame %0d never signalled frame done", n);
      timeout_errs++;
      end_run();
    end
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (o_busy && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (o_busy) begin
      $display("timeout: sequencer stayed busy after frame done");
      timeout_errs++;
      end_run();
    end
  endtask

  task automatic wait_accepted(input int n);
    int cycles;
    cycles = 0;
    while (acc_total < n && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (acc_total < n) begin
      $display("timeout: only %0d of %0d pixels were accepted", acc_total, n);
      timeout_errs++;
      end_run();
    end
  endtask

  task automatic pulse_start();
    @(posedge clk);
    i_start <= 1'b1;
    @(posedge clk);
    i_start <= 1'b0;
  endtask

  initial begin
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    // Offer pixels before any start
    @(posedge clk);
    drive_en <= 1'b1;
    armed    <= 1;
    repeat (8) @(posedge clk);
    pulse_start();
    wait_frames(1);
    wait_idle();

    // Second frame gets a stray start halfway through
    @(posedge clk);
    armed <= 2;
    pulse_start();
    wait_accepted(FRAME_PIX + FRAME_PIX / 2);
    pulse_start();
    wait_frames(2);
    wait_idle();

    @(posedge clk);
    armed <= 3;
    pulse_start();
    wait_frames(3);
    wait_idle();
    repeat (10) @(negedge clk);

    assert (out_total == FRAMES * FRAME_PIX && acc_total == FRAMES * FRAME_PIX)
      else begin
        count_errs++;
        $display("error %0t: %0d pixels in, %0d beats out, expected %0d", $time,
                 acc_total, out_total, FRAMES * FRAME_PIX);
      end
    assert (exp_cnt == 0 && frames_seen == FRAMES)
      else begin
        count_errs++;
        $display("error %0t: %0d beats left, %0d frames done", $time,
                 exp_cnt, frames_seen);
      end
    end_run();
  end

endmodule

//--- all.f
common/integral_pkg.sv
row_sum/frame_sequencer.sv
row_sum/row_prefix.sv
logic/column_accum.sv
logic/integral_top.sv
test/integral_tb.sv

//--- Makefile
# Verilator build for the integral image pipeline

VERILATOR ?= verilator
FILELIST  ?= all.f
TB_TOP    ?= integral_tb
RTL_TOP   ?= integral_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --timing --assert
PASS_MSG  ?= TEST OK

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TB_TOP) --Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	rm -f $(LOG)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
